//--- Makefile
SIM       := verilator
FLAGS     := --binary --timing --assert
TOP       := hazard_detector_tb
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP) and check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
	  echo "result: FAIL"; exit 1; \
	elif grep -q "Testbench passed" $(LOG); then \
	  echo "result: PASS"; \
	else \
	  echo "result: FAIL, no verdict in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/dep_tracker.sv
// Dependency tracker for the execute stages.
// Decodes the instruction dispatched this cycle into a record (valid,
// memory op, register write, rd and forwarding stage) and shifts the
// records down a chain of dep_depth_p stages, one stage per clock edge.
// A cycle without a dispatch loads an empty record into stage 0.

`timescale 1ns/1ps

module dep_tracker
  #(parameter int dep_depth_p = hazard_pkg::DEP_DEPTH_DEFAULT)
  (input                                              clk_i
   , input                                            rst_i
   , input                                            disp_v_i
   , input  hazard_pkg::pipe_class_t                  disp_class_i
   , input                                            disp_rd_w_i
   , input  hazard_pkg::reg_addr_t                    disp_rd_i
   , input                                            disp_mem_i
   , output logic [dep_depth_p-1:0]                   stage_v_o
   , output logic [dep_depth_p-1:0]                   stage_mem_o
   , output logic [dep_depth_p-1:0]                   stage_rd_w_o
   , output logic [dep_depth_p*hazard_pkg::REG_ADDR_W-1:0] stage_rd_o
   , output logic [dep_depth_p*hazard_pkg::FWD_W-1:0] stage_fwd_o
   );

  hazard_pkg::fwd_stage_t rec_fwd;

  logic [dep_depth_p-1:0] v_r;
  logic [dep_depth_p-1:0] mem_r;
  logic [dep_depth_p-1:0] rd_w_r;
  hazard_pkg::reg_addr_t  rd_r  [dep_depth_p];
  hazard_pkg::fwd_stage_t fwd_r [dep_depth_p];

  // forwarding stage by pipe class
  always_comb
  begin
    case (disp_class_i)
      hazard_pkg::PIPE_AUX, hazard_pkg::PIPE_MEM_EARLY: rec_fwd = hazard_pkg::FWD_EX1;
      hazard_pkg::PIPE_MEM_FINAL, hazard_pkg::PIPE_MUL: rec_fwd = hazard_pkg::FWD_EX2;
      // ctl and int forward from ex0, long waits in the scoreboard
      default: rec_fwd = hazard_pkg::FWD_EX0;
    endcase
  end

  // control bits of the record chain
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      v_r    <= '0;
      mem_r  <= '0;
      rd_w_r <= '0;
    end
    else
    begin
      v_r[0]    <= disp_v_i;
      mem_r[0]  <= disp_v_i & disp_mem_i;
      rd_w_r[0] <= disp_v_i & disp_rd_w_i;
      for (int i = 1; i < dep_depth_p; i++)
      begin
        v_r[i]    <= v_r[i-1];
        mem_r[i]  <= mem_r[i-1];
        rd_w_r[i] <= rd_w_r[i-1];
      end
    end
  end

  // register and forwarding fields, only meaningful while the stage is valid
  always_ff @(posedge clk_i)
  begin
    rd_r[0]  <= disp_v_i ? disp_rd_i : '0;
    fwd_r[0] <= disp_v_i ? rec_fwd : hazard_pkg::FWD_EX0;
    for (int i = 1; i < dep_depth_p; i++)
    begin
      rd_r[i]  <= rd_r[i-1];
      fwd_r[i] <= fwd_r[i-1];
    end
  end

  assign stage_v_o    = v_r;
  assign stage_mem_o  = mem_r;
  assign stage_rd_w_o = rd_w_r;

  // flatten the per-stage fields for the resolve block
  always_comb
  begin
    for (int i = 0; i < dep_depth_p; i++)
    begin
      stage_rd_o[i*hazard_pkg::REG_ADDR_W +: hazard_pkg::REG_ADDR_W] = rd_r[i];
      stage_fwd_o[i*hazard_pkg::FWD_W +: hazard_pkg::FWD_W]          = fwd_r[i];
    end
  end

endmodule

//--- design/hazard_detector.sv
// Top level of the issue-stage hazard detector.
// Tracks the instructions in execute stages 1 to dep_depth_p, scores
// late integer write-backs and decides each cycle whether the waiting
// instruction may dispatch. Outputs are combinational from the inputs
// and the internal stage and scoreboard state.

`timescale 1ns/1ps

module hazard_detector
  #(parameter int dep_depth_p = hazard_pkg::DEP_DEPTH_DEFAULT)
  (input                                clk_i
   , input                              rst_i
   // instruction waiting to issue
   , input                              issue_rs1_v_i
   , input                              issue_rs2_v_i
   , input                              issue_rd_v_i
   , input  hazard_pkg::reg_addr_t      issue_rs1_i
   , input  hazard_pkg::reg_addr_t      issue_rs2_i
   , input  hazard_pkg::reg_addr_t      issue_rd_i
   , input                              issue_fence_i
   , input                              issue_mem_i
   , input                              issue_csr_i
   , input                              issue_long_i
   // instruction entering stage 0
   , input                              disp_v_i
   , input  hazard_pkg::pipe_class_t    disp_class_i
   , input                              disp_rd_w_i
   , input  hazard_pkg::reg_addr_t      disp_rd_i
   , input                              disp_mem_i
   // late write-back
   , input                              late_wb_v_i
   , input  hazard_pkg::reg_addr_t      late_wb_rd_i
   // status levels
   , input                              cmd_full_i
   , input                              credits_full_i
   , input                              credits_empty_i
   , input                              idiv_ready_i
   , input                              mem_ready_i
   , input                              ptw_busy_i
   , input                              irq_pending_i
   , output logic                       dispatch_v_o
   , output logic                       interrupt_v_o
   );

  logic [dep_depth_p-1:0]                        stage_v;
  logic [dep_depth_p-1:0]                        stage_mem;
  logic [dep_depth_p-1:0]                        stage_rd_w;
  logic [dep_depth_p*hazard_pkg::REG_ADDR_W-1:0] stage_rd;
  logic [dep_depth_p*hazard_pkg::FWD_W-1:0]      stage_fwd;
  logic                                          rs1_pend, rs2_pend, rd_pend;

  dep_tracker #(.dep_depth_p(dep_depth_p)) dep_tracker_inst
    (.clk_i          (clk_i)
     , .rst_i        (rst_i)
     , .disp_v_i     (disp_v_i)
     , .disp_class_i (disp_class_i)
     , .disp_rd_w_i  (disp_rd_w_i)
     , .disp_rd_i    (disp_rd_i)
     , .disp_mem_i   (disp_mem_i)
     , .stage_v_o    (stage_v)
     , .stage_mem_o  (stage_mem)
     , .stage_rd_w_o (stage_rd_w)
     , .stage_rd_o   (stage_rd)
     , .stage_fwd_o  (stage_fwd)
     );

  int_scoreboard int_scoreboard_inst
    (.clk_i          (clk_i)
     , .rst_i        (rst_i)
     , .disp_v_i     (disp_v_i)
     , .disp_class_i (disp_class_i)
     , .disp_rd_w_i  (disp_rd_w_i)
     , .disp_rd_i    (disp_rd_i)
     , .late_wb_v_i  (late_wb_v_i)
     , .late_wb_rd_i (late_wb_rd_i)
     , .issue_rs1_i  (issue_rs1_i)
     , .issue_rs2_i  (issue_rs2_i)
     , .issue_rd_i   (issue_rd_i)
     , .rs1_pend_o   (rs1_pend)
     , .rs2_pend_o   (rs2_pend)
     , .rd_pend_o    (rd_pend)
     );

  hazard_resolve #(.dep_depth_p(dep_depth_p)) hazard_resolve_inst
    (.issue_rs1_v_i     (issue_rs1_v_i)
     , .issue_rs2_v_i   (issue_rs2_v_i)
     , .issue_rd_v_i    (issue_rd_v_i)
     , .issue_rs1_i     (issue_rs1_i)
     , .issue_rs2_i     (issue_rs2_i)
     , .issue_rd_i      (issue_rd_i)
     , .issue_fence_i   (issue_fence_i)
     , .issue_mem_i     (issue_mem_i)
     , .issue_csr_i     (issue_csr_i)
     , .issue_long_i    (issue_long_i)
     , .stage_v_i       (stage_v)
     , .stage_mem_i     (stage_mem)
     , .stage_rd_w_i    (stage_rd_w)
     , .stage_rd_i      (stage_rd)
     , .stage_fwd_i     (stage_fwd)
     , .rs1_pend_i      (rs1_pend)
     , .rs2_pend_i      (rs2_pend)
     , .rd_pend_i       (rd_pend)
     , .cmd_full_i      (cmd_full_i)
     , .credits_full_i  (credits_full_i)
     , .credits_empty_i (credits_empty_i)
     , .idiv_ready_i    (idiv_ready_i)
     , .mem_ready_i     (mem_ready_i)
     , .ptw_busy_i      (ptw_busy_i)
     , .irq_pending_i   (irq_pending_i)
     , .dispatch_v_o    (dispatch_v_o)
     , .interrupt_v_o   (interrupt_v_o)
     );

endmodule

//--- design/hazard_pkg.sv
// Shared types and constants for the issue-stage hazard detector.
// Blocks take what they need by scoped names, e.g. hazard_pkg::reg_addr_t.
// Pipe class codes tell the dependency tracker which execute stage
// first forwards a result.

package hazard_pkg;

  // integer register number, register 0 never causes a hazard
  localparam int REG_ADDR_W = 5;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // execution pipe of a dispatched instruction
  localparam int PIPE_CLASS_W = 3;
  typedef logic [PIPE_CLASS_W-1:0] pipe_class_t;

  localparam pipe_class_t PIPE_CTL       = 3'd0;
  localparam pipe_class_t PIPE_INT       = 3'd1;
  localparam pipe_class_t PIPE_AUX       = 3'd2;
  localparam pipe_class_t PIPE_MEM_EARLY = 3'd3;
  localparam pipe_class_t PIPE_MEM_FINAL = 3'd4;
  localparam pipe_class_t PIPE_MUL       = 3'd5;
  // long latency, result comes back through the scoreboard
  localparam pipe_class_t PIPE_LONG      = 3'd6;

  // first execute stage index at which the result can be forwarded
  localparam int FWD_W = 2;
  typedef logic [FWD_W-1:0] fwd_stage_t;

  localparam fwd_stage_t FWD_EX0 = 2'd0;
  localparam fwd_stage_t FWD_EX1 = 2'd1;
  localparam fwd_stage_t FWD_EX2 = 2'd2;

  // default number of tracked execute stages
  localparam int DEP_DEPTH_DEFAULT = 3;

  // scoreboard entries, one per integer register
  localparam int NUM_REGS = 32;

endpackage

//--- design/hazard_resolve.sv
// Dispatch decision for the instruction waiting to issue.
// Combines data hazards (stage records and scoreboard), control hazards
// (fence, memory credits, CSR and long serialization) and structural
// hazards into dispatch_v_o. Purely combinational.
// Also gates the interrupt request while a page walk is busy.

`timescale 1ns/1ps

module hazard_resolve
  #(parameter int dep_depth_p = hazard_pkg::DEP_DEPTH_DEFAULT)
  (input                                                   issue_rs1_v_i
   , input                                                 issue_rs2_v_i
   , input                                                 issue_rd_v_i
   , input  hazard_pkg::reg_addr_t                         issue_rs1_i
   , input  hazard_pkg::reg_addr_t                         issue_rs2_i
   , input  hazard_pkg::reg_addr_t                         issue_rd_i
   , input                                                 issue_fence_i
   , input                                                 issue_mem_i
   , input                                                 issue_csr_i
   , input                                                 issue_long_i
   , input  [dep_depth_p-1:0]                              stage_v_i
   , input  [dep_depth_p-1:0]                              stage_mem_i
   , input  [dep_depth_p-1:0]                              stage_rd_w_i
   , input  [dep_depth_p*hazard_pkg::REG_ADDR_W-1:0]       stage_rd_i
   , input  [dep_depth_p*hazard_pkg::FWD_W-1:0]            stage_fwd_i
   , input                                                 rs1_pend_i
   , input                                                 rs2_pend_i
   , input                                                 rd_pend_i
   , input                                                 cmd_full_i
   , input                                                 credits_full_i
   , input                                                 credits_empty_i
   , input                                                 idiv_ready_i
   , input                                                 mem_ready_i
   , input                                                 ptw_busy_i
   , input                                                 irq_pending_i
   , output logic                                          dispatch_v_o
   , output logic                                          interrupt_v_o
   );

  logic [dep_depth_p-1:0] stage_blk;
  logic [dep_depth_p-1:0] rs1_hit;
  logic [dep_depth_p-1:0] rs2_hit;

  logic rs1_haz, rs2_haz, rd_waw_haz;
  logic mem_in_pipe, pipe_busy;
  logic fence_haz, credit_haz, serial_haz;
  logic data_haz, control_haz, struct_haz;

  // a writing stage blocks readers until it reaches its forwarding stage
  for (genvar i = 0; i < dep_depth_p; i++)
  begin : g_stage
    hazard_pkg::reg_addr_t  st_rd;
    hazard_pkg::fwd_stage_t st_fwd;

    assign st_rd  = stage_rd_i[i*hazard_pkg::REG_ADDR_W +: hazard_pkg::REG_ADDR_W];
    assign st_fwd = stage_fwd_i[i*hazard_pkg::FWD_W +: hazard_pkg::FWD_W];

    assign stage_blk[i] = stage_v_i[i] & stage_rd_w_i[i] & (int'(st_fwd) > i);
    assign rs1_hit[i]   = stage_blk[i] & (st_rd == issue_rs1_i);
    assign rs2_hit[i]   = stage_blk[i] & (st_rd == issue_rs2_i);
  end

  // raw against the stages or the scoreboard, waw against the scoreboard
  assign rs1_haz    = issue_rs1_v_i & (issue_rs1_i != '0) & ((|rs1_hit) | rs1_pend_i);
  assign rs2_haz    = issue_rs2_v_i & (issue_rs2_i != '0) & ((|rs2_hit) | rs2_pend_i);
  assign rd_waw_haz = issue_rd_v_i & (issue_rd_i != '0) & rd_pend_i;
  assign data_haz   = rs1_haz | rs2_haz | rd_waw_haz;

  assign mem_in_pipe = |stage_mem_i;
  assign pipe_busy   = |stage_v_i;

  // fence drains memory, csr and long wait for an empty pipe
  assign fence_haz   = issue_fence_i & (~credits_empty_i | mem_in_pipe | ~mem_ready_i);
  assign credit_haz  = issue_mem_i & credits_full_i;
  assign serial_haz  = (issue_csr_i | issue_long_i) & pipe_busy;
  assign control_haz = fence_haz | credit_haz | serial_haz;

  assign struct_haz = ptw_busy_i
                      | cmd_full_i
                      | (issue_mem_i & ~mem_ready_i)
                      | (issue_long_i & ~idiv_ready_i);

  assign dispatch_v_o  = ~(data_haz | control_haz | struct_haz);
  assign interrupt_v_o = irq_pending_i & ~ptw_busy_i;

endmodule

//--- design/int_scoreboard.sv
// Integer scoreboard for late write-backs such as divides.
// A valid long-class dispatch that writes a register sets its pending
// bit; a late write-back clears it. Both take effect after the next edge,
// and a score beats a clear of the same register in the same cycle.
// The pending bits of the three issue registers are read out directly.

`timescale 1ns/1ps

module int_scoreboard
  (input                                clk_i
   , input                              rst_i
   , input                              disp_v_i
   , input  hazard_pkg::pipe_class_t    disp_class_i
   , input                              disp_rd_w_i
   , input  hazard_pkg::reg_addr_t      disp_rd_i
   , input                              late_wb_v_i
   , input  hazard_pkg::reg_addr_t      late_wb_rd_i
   , input  hazard_pkg::reg_addr_t      issue_rs1_i
   , input  hazard_pkg::reg_addr_t      issue_rs2_i
   , input  hazard_pkg::reg_addr_t      issue_rd_i
   , output logic                       rs1_pend_o
   , output logic                       rs2_pend_o
   , output logic                       rd_pend_o
   );

  logic [hazard_pkg::NUM_REGS-1:0] pend_r;
  logic                            score_v;

  assign score_v = disp_v_i & disp_rd_w_i & (disp_class_i == hazard_pkg::PIPE_LONG);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      pend_r <= '0;
    end
    else
    begin
      if (late_wb_v_i)
        pend_r[late_wb_rd_i] <= 1'b0;
      // last assignment wins, so a same-cycle score keeps the bit set
      if (score_v)
        pend_r[disp_rd_i] <= 1'b1;
    end
  end

  assign rs1_pend_o = pend_r[issue_rs1_i];
  assign rs2_pend_o = pend_r[issue_rs2_i];
  assign rd_pend_o  = pend_r[issue_rd_i];

endmodule

//--- flist.f
design/hazard_pkg.sv
design/dep_tracker.sv
design/int_scoreboard.sv
design/hazard_resolve.sv
design/hazard_detector.sv
tests/hazard_detector_assert.sv
tests/hazard_detector_tb.sv

//--- tests/hazard_detector_assert.sv
// Concurrent checks on the hazard detector, bound to its top level.
// Covers interrupt gating by the page walk, the command queue stall
// and dispatch from a clean pipeline right after reset.

`timescale 1ns/1ps

module hazard_detector_assert
  (input logic clk_i
   , input logic rst_i
   , input logic issue_rs1_v_i, issue_rs2_v_i, issue_rd_v_i
   , input logic issue_fence_i, issue_mem_i, issue_csr_i, issue_long_i
   , input logic cmd_full_i
   , input logic ptw_busy_i
   , input logic dispatch_v_o
   , input logic interrupt_v_o
   );

  logic issue_idle;

  assign issue_idle = ~(issue_rs1_v_i | issue_rs2_v_i | issue_rd_v_i | issue_fence_i
                        | issue_mem_i | issue_csr_i | issue_long_i);

  irq_gated_by_ptw: assert property (@(posedge clk_i) disable iff (rst_i)
                                     ptw_busy_i |-> !interrupt_v_o)
    else $error("interrupt_v_o high while a page walk is busy");

  cmd_full_stalls: assert property (@(posedge clk_i) disable iff (rst_i)
                                    cmd_full_i |-> !dispatch_v_o)
    else $error("dispatch_v_o high while the command queue is full");

  // stage records and scoreboard are empty in the first cycle out of reset
  dispatch_after_reset: assert property (@(posedge clk_i)
                                         ($past(rst_i) && !rst_i && issue_idle
                                          && !cmd_full_i && !ptw_busy_i) |-> dispatch_v_o)
    else $error("dispatch_v_o low in the first idle cycle after reset");

endmodule

bind hazard_detector hazard_detector_assert hazard_detector_assert_inst
  (.clk_i(clk_i), .rst_i(rst_i)
   , .issue_rs1_v_i(issue_rs1_v_i), .issue_rs2_v_i(issue_rs2_v_i)
   , .issue_rd_v_i(issue_rd_v_i), .issue_fence_i(issue_fence_i)
   , .issue_mem_i(issue_mem_i), .issue_csr_i(issue_csr_i)
   , .issue_long_i(issue_long_i), .cmd_full_i(cmd_full_i)
   , .ptw_busy_i(ptw_busy_i), .dispatch_v_o(dispatch_v_o)
   , .interrupt_v_o(interrupt_v_o));

//--- tests/hazard_detector_tb.sv
// Testbench for the issue-stage hazard detector.
// Reads tests/hazard_stimulus.txt, one cycle per line, drives the inputs
// 2 ns after the rising edge and checks dispatch_v_o and interrupt_v_o
// just before the next edge. Lines marked don't-care get random values in
// their idle register fields. Run from the project root.

`timescale 1ns/1ps

module hazard_detector_tb;

  localparam int    clk_period_p   = 40;
  localparam int    reset_cycles_p = 10;
  localparam int    drive_delay_p  = 2;
  localparam int    num_fields_p   = 27;
  localparam string stim_file_p    = "tests/hazard_stimulus.txt";

  logic clk_i, rst_i;
  logic issue_rs1_v_i, issue_rs2_v_i, issue_rd_v_i;
  hazard_pkg::reg_addr_t issue_rs1_i, issue_rs2_i, issue_rd_i;
  logic issue_fence_i, issue_mem_i, issue_csr_i, issue_long_i;
  logic disp_v_i, disp_rd_w_i, disp_mem_i;
  hazard_pkg::pipe_class_t disp_class_i;
  hazard_pkg::reg_addr_t   disp_rd_i;
  logic late_wb_v_i;
  hazard_pkg::reg_addr_t late_wb_rd_i;
  logic cmd_full_i, credits_full_i, credits_empty_i, idiv_ready_i;
  logic mem_ready_i, ptw_busy_i, irq_pending_i;
  logic dispatch_v_o, interrupt_v_o;

  string stim_lines[$];
  int    cycle_count = 0;
  int    cycle_limit = 1000;

  hazard_detector #(.dep_depth_p(hazard_pkg::DEP_DEPTH_DEFAULT)) hazard_detector_inst (.*);

  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #(clk_period_p / 2);
      clk_i = ~clk_i;
    end
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  // hold reset with an idle pipeline and no hazards
  task automatic init_inputs();
    rst_i = 1'b1;
    {issue_rs1_v_i, issue_rs2_v_i, issue_rd_v_i} = '0;
    {issue_rs1_i, issue_rs2_i, issue_rd_i} = '0;
    {issue_fence_i, issue_mem_i, issue_csr_i, issue_long_i} = '0;
    {disp_v_i, disp_rd_w_i, disp_mem_i} = '0;
    disp_class_i = hazard_pkg::PIPE_CTL;
    disp_rd_i = '0;
    late_wb_v_i = 1'b0;
    late_wb_rd_i = '0;
    {cmd_full_i, credits_full_i, ptw_busy_i, irq_pending_i} = '0;
    {credits_empty_i, idiv_ready_i, mem_ready_i} = '1;
  endtask

  task automatic load_stimulus();
    int    fd;
    string line;
    fd = $fopen(stim_file_p, "r");
    assert (fd != 0)
    else
      stop_on_error({"could not open stimulus file ", stim_file_p});
    // comment lines start with '#'
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() > 1 && line.getc(0) != "#")
        stim_lines.push_back(line);
    end
    $fclose(fd);
    assert (stim_lines.size() > 0)
    else
      stop_on_error("stimulus file holds no stimulus lines");
  endtask

  task automatic apply_line(input string line, input int line_no,
                            output logic exp_disp, output logic exp_irq);
    int fld [num_fields_p];
    int count;
    count = $sscanf(line, "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                    fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                    fld[6], fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                    fld[14], fld[15], fld[16], fld[17], fld[18], fld[19], fld[20],
                    fld[21], fld[22], fld[23], fld[24], fld[25], fld[26]);
    assert (count == num_fields_p)
    else
      stop_on_error($sformatf("stimulus line %0d is malformed, only %0d fields read",
                              line_no, count));
    // register fields of a don't-care line without a valid bit get random values
    if (fld[0] != 0)
    begin
      if (fld[1] == 0)
        fld[4] = $urandom_range(hazard_pkg::NUM_REGS - 1, 0);
      if (fld[2] == 0)
        fld[5] = $urandom_range(hazard_pkg::NUM_REGS - 1, 0);
      if (fld[3] == 0)
        fld[6] = $urandom_range(hazard_pkg::NUM_REGS - 1, 0);
      if (fld[11] == 0)
        fld[14] = $urandom_range(hazard_pkg::NUM_REGS - 1, 0);
      if (fld[16] == 0)
        fld[17] = $urandom_range(hazard_pkg::NUM_REGS - 1, 0);
    end
    issue_rs1_v_i   = fld[1][0];
    issue_rs2_v_i   = fld[2][0];
    issue_rd_v_i    = fld[3][0];
    issue_rs1_i     = hazard_pkg::reg_addr_t'(fld[4]);
    issue_rs2_i     = hazard_pkg::reg_addr_t'(fld[5]);
    issue_rd_i      = hazard_pkg::reg_addr_t'(fld[6]);
    issue_fence_i   = fld[7][0];
    issue_mem_i     = fld[8][0];
    issue_csr_i     = fld[9][0];
    issue_long_i    = fld[10][0];
    disp_v_i        = fld[11][0];
    disp_class_i    = hazard_pkg::pipe_class_t'(fld[12]);
    disp_rd_w_i     = fld[13][0];
    disp_rd_i       = hazard_pkg::reg_addr_t'(fld[14]);
    disp_mem_i      = fld[15][0];
    late_wb_v_i     = fld[16][0];
    late_wb_rd_i    = hazard_pkg::reg_addr_t'(fld[17]);
    cmd_full_i      = fld[18][0];
    credits_full_i  = fld[19][0];
    credits_empty_i = fld[20][0];
    idiv_ready_i    = fld[21][0];
    mem_ready_i     = fld[22][0];
    ptw_busy_i      = fld[23][0];
    irq_pending_i   = fld[24][0];
    exp_disp        = fld[25][0];
    exp_irq         = fld[26][0];
  endtask

  task automatic check_outputs(input int line_no, input logic exp_disp, input logic exp_irq);
    assert (dispatch_v_o === exp_disp)
    else
      stop_on_error($sformatf("FAILED line %0d: dispatch_v_o = %h, expected %h",
                              line_no, dispatch_v_o, exp_disp));
    assert (interrupt_v_o === exp_irq)
    else
      stop_on_error($sformatf("FAILED line %0d: interrupt_v_o = %h, expected %h",
                              line_no, interrupt_v_o, exp_irq));
  endtask

  // run limit covers reset, every stimulus line and some margin
  always @(posedge clk_i)
  begin
    cycle_count = cycle_count + 1;
    assert (cycle_count < cycle_limit)
    else
      stop_on_error($sformatf("timeout, run did not finish within %0d cycles", cycle_limit));
  end

  initial
  begin
    logic exp_disp;
    logic exp_irq;
    init_inputs();
    void'($urandom(33840));
    load_stimulus();
    cycle_limit = stim_lines.size() + reset_cycles_p + 20;
    repeat (reset_cycles_p) @(posedge clk_i);
    #(drive_delay_p);
    rst_i = 1'b0;
    for (int n = 0; n < stim_lines.size(); n++)
    begin
      apply_line(stim_lines[n], n + 1, exp_disp, exp_irq);
      // sample 2 ns before the next rising edge
      #(clk_period_p - drive_delay_p - 2);
      check_outputs(n + 1, exp_disp, exp_irq);
      @(posedge clk_i);
      #(drive_delay_p);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- tests/hazard_stimulus.txt
# dc rs1v rs2v rdv rs1 rs2 rd fence mem csr long | dv class rdw drd dmem | wbv wbrd
# cmdfull credfull credempty divrdy memrdy ptw irq | expected dispatch interrupt (all hex)
1 0 0 0 00 00 00 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 1 0
0 0 0 0 00 00 00 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 1 0
# forwarding windows: aux, mul, int writers of r5, reader of r0
0 0 0 0 00 00 00 0 0 0 0 1 2 1 05 0 0 00 0 0 1 1 1 0 0 1 0
0 1 0 0 05 00 00 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 0 0
0 1 0 0 05 00 00 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 1 0
0 0 0 0 00 00 00 0 0 0 0 1 5 1 05 0 0 00 0 0 1 1 1 0 0 1 0
0 0 1 0 00 05 00 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 0 0
0 0 1 0 00 05 00 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 0 0
0 0 1 0 00 05 00 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 1 0
0 0 0 0 00 00 00 0 0 0 0 1 1 1 05 0 0 00 0 0 1 1 1 0 0 1 0
0 1 0 0 05 00 00 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 1 0
0 0 0 0 00 00 00 0 0 0 0 1 5 1 00 0 0 00 0 0 1 1 1 0 0 1 0
1 1 1 0 00 00 00 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 1 0
1 0 0 0 00 00 00 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 1 0
# scoreboard: long write of r7, then r10 scored and cleared in one cycle
0 0 0 0 00 00 00 0 0 0 0 1 6 1 07 0 0 00 0 0 1 1 1 0 0 1 0
0 1 0 0 07 00 00 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 0 0
0 0 0 1 00 00 07 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 0 0
0 0 1 0 00 07 00 0 0 0 0 0 0 0 00 0 1 07 0 0 1 1 1 0 0 0 0
0 1 0 1 07 00 07 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 1 0
0 0 0 0 00 00 00 0 0 0 0 1 6 1 0a 0 0 00 0 0 1 1 1 0 0 1 0
0 1 0 0 0a 00 00 0 0 0 0 1 6 1 0a 0 1 0a 0 0 1 1 1 0 0 0 0
0 1 0 0 0a 00 00 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 0 0
0 1 0 0 0a 00 00 0 0 0 0 0 0 0 00 0 1 0a 0 0 1 1 1 0 0 0 0
0 1 0 0 0a 00 00 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 1 0
# fence and memory credits
0 0 0 0 00 00 00 1 0 0 0 0 0 0 00 0 0 00 0 0 0 1 1 0 0 0 0
0 0 0 0 00 00 00 1 0 0 0 0 0 0 00 0 0 00 0 0 1 1 0 0 0 0 0
0 0 0 0 00 00 00 1 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 1 0
0 0 0 0 00 00 00 0 0 0 0 1 3 1 0c 1 0 00 0 0 1 1 1 0 0 1 0
0 0 0 0 00 00 00 1 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 0 0
0 0 0 0 00 00 00 1 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 0 0
0 0 0 0 00 00 00 1 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 0 0
0 0 0 0 00 00 00 1 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 1 0
0 0 0 0 00 00 00 0 1 0 0 0 0 0 00 0 0 00 0 1 1 1 1 0 0 0 0
0 0 0 0 00 00 00 0 1 0 0 0 0 0 00 0 0 00 0 0 1 1 0 0 0 0 0
0 0 0 0 00 00 00 0 1 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 1 0
# csr and long serialization, divider ready
0 0 0 0 00 00 00 0 0 1 0 1 1 1 03 0 0 00 0 0 1 1 1 0 0 1 0
0 0 0 0 00 00 00 0 0 1 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 0 0
0 0 0 0 00 00 00 0 0 1 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 0 0
0 0 0 0 00 00 00 0 0 1 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 0 0
0 0 0 0 00 00 00 0 0 1 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 1 0
0 0 0 0 00 00 00 0 0 0 1 1 0 0 00 0 0 00 0 0 1 1 1 0 0 1 0
0 0 0 0 00 00 00 0 0 0 1 0 0 0 00 0 0 00 0 0 1 1 1 0 0 0 0
0 0 0 0 00 00 00 0 0 0 1 0 0 0 00 0 0 00 0 0 1 1 1 0 0 0 0
0 0 0 0 00 00 00 0 0 0 1 0 0 0 00 0 0 00 0 0 1 1 1 0 0 0 0
0 0 0 0 00 00 00 0 0 0 1 0 0 0 00 0 0 00 0 0 1 0 1 0 0 0 0
0 0 0 0 00 00 00 0 0 0 1 0 0 0 00 0 0 00 0 0 1 1 1 0 0 1 0
# structural hazards and interrupt gating
0 0 0 0 00 00 00 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 1 1 0 0
0 0 0 0 00 00 00 0 0 0 0 0 0 0 00 0 0 00 1 0 1 1 1 0 1 0 1
0 0 0 0 00 00 00 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 1 1 1
0 1 0 0 04 00 00 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 1 0 0 0
1 0 0 0 00 00 00 0 0 0 0 0 0 0 00 0 0 00 0 0 1 1 1 0 0 1 0
